/* logic/trace_pkg.sv */
// ----------------------------
// Shared types for the commit monitor.
// Commit entries, trace entries, perf events and the counter address map.
// ----------------------------
`default_nettype none

package trace_pkg;

  localparam int unsigned XLEN = 64;
  localparam int unsigned VLEN = 64;

  // Port count the index width is derived from
  localparam int unsigned DefaultCommitPorts = 2;
  localparam int unsigned PortIdxWidth =
    (DefaultCommitPorts > 1) ? $clog2(DefaultCommitPorts) : 1;

  localparam int unsigned NrPerfCounters = 11;

  typedef logic [31:0] ilen_t;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // Cause word, raw or split into interrupt flag and code
  typedef union packed {
    logic [XLEN-1:0] raw;
    struct packed {
      logic            irq;
      logic [XLEN-2:0] code;
    } fields;
  } cause_u;

  typedef struct packed {
    logic            valid;
    cause_u          cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  typedef struct packed {
    logic [VLEN-1:0] pc;
    exception_t      ex;
  } commit_entry_t;

  typedef struct packed {
    logic            valid;
    logic            exception;
    logic            interrupt;
    priv_lvl_t       priv;
    logic [VLEN-1:0] iaddr;
    ilen_t           insn;
    logic [XLEN-1:0] cause;
    ilen_t           tval;
  } trace_entry_t;

  // sb_full and if_empty are levels, the rest single-cycle pulses
  typedef struct packed {
    logic icache_miss;
    logic dcache_miss;
    logic itlb_miss;
    logic dtlb_miss;
    logic sb_full;
    logic if_empty;
    logic eret;
  } perf_events_t;

  typedef logic [4:0] perf_addr_t;

  typedef enum perf_addr_t {
    CYCLE       = 5'd0,
    INSTRET     = 5'd1,
    ICACHE_MISS = 5'd2,
    DCACHE_MISS = 5'd3,
    ITLB_MISS   = 5'd4,
    DTLB_MISS   = 5'd5,
    EXCEPTION   = 5'd6,
    INTERRUPT   = 5'd7,
    ERET        = 5'd8,
    SB_FULL     = 5'd9,
    IF_EMPTY    = 5'd10
  } perf_ctr_e;

endpackage

`default_nettype wire

/* logic/commit_trace.sv */
// ----------------------------
// Classifies each acknowledged commit port as a retire,
// an exception or an interrupt. Purely combinational.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module commit_trace import trace_pkg::*; #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  commit_entry_t [NrCommitPorts-1:0] commit_instr_i,
  input  logic          [NrCommitPorts-1:0] commit_ack_i,
  input  priv_lvl_t                         priv_lvl_i,
  output trace_entry_t  [NrCommitPorts-1:0] trace_o
);

  always_comb begin
    logic ack;
    logic has_ex;
    logic is_irq;

    ack    = 1'b0;
    has_ex = 1'b0;
    is_irq = 1'b0;
    trace_o = '0;

    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      ack    = commit_ack_i[p];
      has_ex = commit_instr_i[p].ex.valid;
      // Interrupts carry the top bit of the cause word
      is_irq = commit_instr_i[p].ex.cause.fields.irq;

      trace_o[p].valid     = ack & ~has_ex;
      trace_o[p].exception = ack & has_ex & ~is_irq;
      trace_o[p].interrupt = ack & has_ex & is_irq;

      // Payload
      trace_o[p].priv  = priv_lvl_i;
      trace_o[p].iaddr = commit_instr_i[p].pc;
      trace_o[p].insn  = commit_instr_i[p].ex.tval[31:0];
      trace_o[p].cause = commit_instr_i[p].ex.cause.raw;
      // tval shares the low word with insn
      trace_o[p].tval  = commit_instr_i[p].ex.tval[31:0];
    end
  end

endmodule

`default_nettype wire

/* logic/pc_queue.sv */
// ----------------------------
// Circular FIFO of retired PCs for one commit port.
// A push into a full queue is dropped.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module pc_queue import trace_pkg::*; #(
  parameter int unsigned PcQueueDepth = 16
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            push_i,
  input  logic [VLEN-1:0] pc_i,
  input  logic            pop_i,
  output logic [VLEN-1:0] pc_o,
  output logic            empty_o
);

  localparam int unsigned PtrWidth = (PcQueueDepth > 1) ? $clog2(PcQueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(PcQueueDepth + 1);

  logic [VLEN-1:0]     mem_q [PcQueueDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;

  logic full;
  logic push_ok;
  logic pop_ok;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == CntWidth'(PcQueueDepth));
  assign push_ok = push_i & ~full;
  assign pop_ok  = pop_i & ~empty_o;

  assign pc_o = mem_q[rd_ptr_q];

  // ----------------------------
  // Pointers and fill count
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(PcQueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(PcQueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= pc_i;
    end
  end

endmodule

`default_nettype wire

/* logic/pc_rr_arbiter.sv */
// ----------------------------
// Round-robin pick of one non-empty PC queue per cycle.
// The grant pops the chosen queue in the same cycle.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module pc_rr_arbiter import trace_pkg::*; #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [NrCommitPorts-1:0][VLEN-1:0]  pc_i,
  input  logic [NrCommitPorts-1:0]            empty_i,
  output logic [NrCommitPorts-1:0]            pop_o,
  output logic                                pc_valid_o,
  output logic [VLEN-1:0]                     pc_o
);

  logic [PortIdxWidth-1:0] prio_q;
  logic [PortIdxWidth-1:0] gnt_idx;
  logic                    gnt_valid;

  // First non-empty queue at or after the priority pointer
  always_comb begin
    int unsigned idx;

    idx       = 0;
    gnt_valid = 1'b0;
    gnt_idx   = '0;
    for (int unsigned k = 0; k < NrCommitPorts; k++) begin
      idx = (prio_q + k) % NrCommitPorts;
      if (!gnt_valid && !empty_i[idx]) begin
        gnt_valid = 1'b1;
        gnt_idx   = PortIdxWidth'(idx);
      end
    end
  end

  always_comb begin
    pop_o          = '0;
    pop_o[gnt_idx] = gnt_valid;
  end

  assign pc_valid_o = gnt_valid;
  assign pc_o       = pc_i[gnt_idx];

  // Priority moves past the last winner
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= '0;
    end else if (gnt_valid) begin
      prio_q <= (gnt_idx == PortIdxWidth'(NrCommitPorts - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/perf_counters.sv */
// ----------------------------
// Eleven 64-bit performance counters with a CSR-style access port.
// Counting stops in debug mode; writes always take effect.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module perf_counters import trace_pkg::*; #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              debug_mode_i,
  input  trace_entry_t [NrCommitPorts-1:0]  trace_i,
  input  perf_events_t                      events_i,
  input  perf_addr_t                        addr_i,
  input  logic                              we_i,
  input  logic [XLEN-1:0]                   wdata_i,
  output logic [XLEN-1:0]                   rdata_o
);

  logic [NrPerfCounters-1:0][XLEN-1:0] ctr_q;
  logic [NrPerfCounters-1:0][XLEN-1:0] ctr_d;

  logic [XLEN-1:0] retire_cnt;
  logic [XLEN-1:0] exc_cnt;
  logic [XLEN-1:0] irq_cnt;
  logic            addr_mapped;

  assign addr_mapped = (addr_i < perf_addr_t'(NrPerfCounters));

  // ----------------------------
  // Per-cycle commit counts
  // ----------------------------
  always_comb begin
    retire_cnt = '0;
    exc_cnt    = '0;
    irq_cnt    = '0;
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      retire_cnt = retire_cnt + XLEN'(trace_i[p].valid);
      exc_cnt    = exc_cnt + XLEN'(trace_i[p].exception);
      irq_cnt    = irq_cnt + XLEN'(trace_i[p].interrupt);
    end
  end

  // ----------------------------
  // Next counter values
  // ----------------------------
  always_comb begin
    ctr_d = ctr_q;

    if (!debug_mode_i) begin
      ctr_d[CYCLE]       = ctr_q[CYCLE] + XLEN'(1);
      ctr_d[INSTRET]     = ctr_q[INSTRET] + retire_cnt;
      ctr_d[EXCEPTION]   = ctr_q[EXCEPTION] + exc_cnt;
      ctr_d[INTERRUPT]   = ctr_q[INTERRUPT] + irq_cnt;
      ctr_d[ICACHE_MISS] = ctr_q[ICACHE_MISS] + XLEN'(events_i.icache_miss);
      ctr_d[DCACHE_MISS] = ctr_q[DCACHE_MISS] + XLEN'(events_i.dcache_miss);
      ctr_d[ITLB_MISS]   = ctr_q[ITLB_MISS] + XLEN'(events_i.itlb_miss);
      ctr_d[DTLB_MISS]   = ctr_q[DTLB_MISS] + XLEN'(events_i.dtlb_miss);
      ctr_d[ERET]        = ctr_q[ERET] + XLEN'(events_i.eret);
      // Level events count every high cycle
      ctr_d[SB_FULL]     = ctr_q[SB_FULL] + XLEN'(events_i.sb_full);
      ctr_d[IF_EMPTY]    = ctr_q[IF_EMPTY] + XLEN'(events_i.if_empty);
    end

    // Write wins over the increment of the same counter
    if (we_i && addr_mapped) begin
      ctr_d[addr_i] = wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_d;
    end
  end

  // Unmapped addresses read as zero
  assign rdata_o = addr_mapped ? ctr_q[addr_i] : '0;

endmodule

`default_nettype wire

/* logic/commit_monitor.sv */
// ----------------------------
// Commit-side monitor top level.
// Trace port, retired-PC stream and performance counters.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module commit_monitor import trace_pkg::*; #(
  parameter int unsigned NrCommitPorts = DefaultCommitPorts,
  parameter int unsigned PcQueueDepth  = 16
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  commit_entry_t [NrCommitPorts-1:0] commit_instr_i,
  input  logic          [NrCommitPorts-1:0] commit_ack_i,
  input  priv_lvl_t                         priv_lvl_i,
  input  logic                              debug_mode_i,
  input  perf_events_t                      events_i,
  input  perf_addr_t                        perf_addr_i,
  input  logic                              perf_we_i,
  input  logic [XLEN-1:0]                   perf_wdata_i,
  output logic [XLEN-1:0]                   perf_rdata_o,
  output trace_entry_t  [NrCommitPorts-1:0] trace_o,
  output logic                              pc_valid_o,
  output logic [VLEN-1:0]                   pc_o
);

  logic [NrCommitPorts-1:0][VLEN-1:0] queue_pc;
  logic [NrCommitPorts-1:0]           queue_empty;
  logic [NrCommitPorts-1:0]           queue_pop;

  // Classification
  commit_trace #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_commit_trace (
    .commit_instr_i ( commit_instr_i ),
    .commit_ack_i   ( commit_ack_i   ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .trace_o        ( trace_o        )
  );

  // ----------------------------
  // Retired-PC stream
  // ----------------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_pc_queue
    pc_queue #(
      .PcQueueDepth ( PcQueueDepth )
    ) i_pc_queue (
      .clk_i   ( clk_i            ),
      .rst_ni  ( rst_ni           ),
      .push_i  ( trace_o[i].valid ),
      .pc_i    ( trace_o[i].iaddr ),
      .pop_i   ( queue_pop[i]     ),
      .pc_o    ( queue_pc[i]      ),
      .empty_o ( queue_empty[i]   )
    );
  end

  pc_rr_arbiter #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_pc_rr_arbiter (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .pc_i       ( queue_pc    ),
    .empty_i    ( queue_empty ),
    .pop_o      ( queue_pop   ),
    .pc_valid_o ( pc_valid_o  ),
    .pc_o       ( pc_o        )
  );

  // Counters
  perf_counters #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_perf_counters (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .debug_mode_i ( debug_mode_i ),
    .trace_i      ( trace_o      ),
    .events_i     ( events_i     ),
    .addr_i       ( perf_addr_i  ),
    .we_i         ( perf_we_i    ),
    .wdata_i      ( perf_wdata_i ),
    .rdata_o      ( perf_rdata_o )
  );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// ----------------------------
// Testbench clock and reset source.
// Reset is held low for a number of clock cycles.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release 1 ns after the last reset edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_commit_monitor.sv */
// ----------------------------
// Directed testbench for the commit monitor.
// Trace classification, PC stream order and counter behavior.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_commit_monitor import trace_pkg::*; ();

  localparam int unsigned NrPorts     = 2;
  localparam int unsigned Depth       = 16;
  localparam int unsigned ClkPeriodNs = 8;
  localparam int unsigned Burst       = 6;
  // Cycle budget of each test in run order
  localparam int unsigned TestCycles  =
    6 + 12 + 7 + (2 * Burst + 1) + 13 + 8;
  localparam int unsigned RunLimitNs  = (TestCycles + 40) * ClkPeriodNs;

  logic                        clk;
  logic                        rst_n;
  commit_entry_t [NrPorts-1:0] commit_instr;
  logic          [NrPorts-1:0] commit_ack;
  priv_lvl_t                   priv_lvl;
  logic                        debug_mode;
  perf_events_t                events;
  perf_addr_t                  perf_addr;
  logic                        perf_we;
  logic [XLEN-1:0]             perf_wdata;
  logic [XLEN-1:0]             perf_rdata;
  trace_entry_t  [NrPorts-1:0] trace_out;
  logic                        pc_valid;
  logic [VLEN-1:0]             pc;
  integer                      errors;
  integer                      seed;

  tb_clock_gen #(.PeriodNs(ClkPeriodNs), .ResetCycles(5)) i_clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  commit_monitor #(.NrCommitPorts(NrPorts), .PcQueueDepth(Depth)) dut0 (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .commit_instr_i ( commit_instr ),
    .commit_ack_i   ( commit_ack   ),
    .priv_lvl_i     ( priv_lvl     ),
    .debug_mode_i   ( debug_mode   ),
    .events_i       ( events       ),
    .perf_addr_i    ( perf_addr    ),
    .perf_we_i      ( perf_we      ),
    .perf_wdata_i   ( perf_wdata   ),
    .perf_rdata_o   ( perf_rdata   ),
    .trace_o        ( trace_out    ),
    .pc_valid_o     ( pc_valid     ),
    .pc_o           ( pc           )
  );

  // ----------------------------
  // Helpers and compare tasks
  // ----------------------------
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_inputs();
    commit_instr = '0;
    commit_ack   = '0;
    events       = '0;
    perf_we      = 1'b0;
  endtask

  function automatic logic [63:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Expected entry from the classification rule
  function automatic trace_entry_t expect_trace(commit_entry_t c, logic ack, priv_lvl_t priv);
    trace_entry_t t;
    t           = '0;
    t.valid     = ack && !c.ex.valid;
    t.exception = ack && c.ex.valid && !c.ex.cause.raw[XLEN-1];
    t.interrupt = ack && c.ex.valid && c.ex.cause.raw[XLEN-1];
    t.priv      = priv;
    t.iaddr     = c.pc;
    t.insn      = c.ex.tval[31:0];
    t.cause     = c.ex.cause.raw;
    t.tval      = c.ex.tval[31:0];
    return t;
  endfunction

  task automatic check_trace(input trace_entry_t got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pc(input logic [VLEN-1:0] got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input logic [XLEN-1:0] got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic read_all_counters(output logic [NrPerfCounters-1:0][XLEN-1:0] v);
    for (int a = 0; a < NrPerfCounters; a++) begin
      perf_addr = perf_addr_t'(a);
      #0.1;
      v[a] = perf_rdata;
    end
  endtask

  // ----------------------------
  // Tests
  // ----------------------------
  task automatic reset_state();
    logic [NrPerfCounters-1:0][XLEN-1:0] v;
    wait (rst_n === 1'b1);
    check_flag(pc_valid, 1'b0, "pc_valid after reset");
    for (int p = 0; p < NrPorts; p++) begin
      check_flag(trace_out[p].valid, 1'b0, "trace valid after reset");
    end
    read_all_counters(v);
    for (int a = 0; a < NrPerfCounters; a++) begin
      check_count(v[a], '0, $sformatf("counter %0d after reset", a));
    end
    next_cycle();
  endtask

  task automatic trace_classification();
    commit_entry_t c;
    priv_lvl_t     levels [3];
    int            port;
    levels = '{PRIV_LVL_U, PRIV_LVL_S, PRIV_LVL_M};
    for (int l = 0; l < 3; l++) begin
      // Retire on port 0, exception on port 1, interrupt on port 0
      for (int kind = 0; kind < 3; kind++) begin
        port           = (kind == 1) ? 1 : 0;
        c.pc           = random_word();
        c.ex.valid     = (kind != 0);
        c.ex.cause.raw = {(kind == 2), 58'd0, 5'($random(seed))};
        c.ex.tval      = random_word();
        idle_inputs();
        priv_lvl           = levels[l];
        commit_instr[port] = c;
        commit_ack[port]   = 1'b1;
        #2;
        check_trace(trace_out[port], expect_trace(c, 1'b1, levels[l]), "acked port");
        check_trace(trace_out[1-port], expect_trace(commit_instr[1-port], 1'b0, levels[l]),
                    "idle port");
        next_cycle();
      end
    end
    idle_inputs();
    repeat (3) next_cycle();
  endtask

  task automatic single_port_stream();
    logic [VLEN-1:0] pcs [6];
    for (int i = 0; i <= 6; i++) begin
      idle_inputs();
      if (i < 6) begin
        pcs[i]             = random_word();
        commit_instr[0].pc = pcs[i];
        commit_ack[0]      = 1'b1;
      end
      #2;
      check_flag(pc_valid, i > 0, "single port pc_valid");
      if (i > 0) check_pc(pc, pcs[i-1], "single port PC");
      next_cycle();
    end
    check_flag(pc_valid, 1'b0, "stream idle after last PC");
  endtask

  task automatic dual_port_arbitration();
    logic [VLEN-1:0] q0 [$];
    logic [VLEN-1:0] q1 [$];
    logic [VLEN-1:0] exp_pc;
    int              prio;
    int              seen;
    int              cyc;
    // Only port 0 has been granted so far, so port 1 is first in line
    prio = 1;
    seen = 0;
    cyc  = 0;
    while ((cyc < Burst || q0.size() > 0 || q1.size() > 0) && cyc < 40) begin
      idle_inputs();
      if (cyc < Burst) begin
        commit_instr[0].pc = random_word();
        commit_instr[1].pc = random_word();
        commit_ack         = '1;
      end
      #2;
      // PCs actually delivered by the DUT
      if (pc_valid) begin
        seen++;
      end
      if (q0.size() == 0 && q1.size() == 0) begin
        check_flag(pc_valid, 1'b0, "arbiter idle");
      end else begin
        if (q1.size() > 0 && (prio == 1 || q0.size() == 0)) begin
          exp_pc = q1.pop_front();
          prio   = 0;
        end else begin
          exp_pc = q0.pop_front();
          prio   = 1;
        end
        check_flag(pc_valid, 1'b1, "arbiter grant");
        check_pc(pc, exp_pc, "arbiter order");
      end
      if (cyc < Burst) begin
        q0.push_back(commit_instr[0].pc);
        q1.push_back(commit_instr[1].pc);
      end
      next_cycle();
      cyc++;
    end
    check_flag(pc_valid, 1'b0, "stream idle after burst");
    check_count(XLEN'(seen), XLEN'(2 * Burst), "PCs delivered in burst");
  endtask

  task automatic counter_accumulation();
    logic [NrPerfCounters-1:0][XLEN-1:0] base;
    logic [NrPerfCounters-1:0][XLEN-1:0] now;
    logic [NrPerfCounters-1:0][XLEN-1:0] delta;
    logic [31:0]                         r;
    delta = '0;
    read_all_counters(base);
    for (int k = 0; k < 12; k++) begin
      idle_inputs();
      r = $random(seed);
      for (int p = 0; p < NrPorts; p++) begin
        commit_instr[p].pc           = random_word();
        commit_instr[p].ex.valid     = r[2*p];
        commit_instr[p].ex.cause.raw = {r[2*p+1], 63'd2};
        commit_ack[p]                = r[4+p];
        if (r[4+p] && !r[2*p]) delta[INSTRET] += 1;
        if (r[4+p] && r[2*p] && !r[2*p+1]) delta[EXCEPTION] += 1;
        if (r[4+p] && r[2*p] && r[2*p+1]) delta[INTERRUPT] += 1;
      end
      events = perf_events_t'(r[14:8]);
      delta[ICACHE_MISS] += XLEN'(events.icache_miss);
      delta[DCACHE_MISS] += XLEN'(events.dcache_miss);
      delta[ITLB_MISS]   += XLEN'(events.itlb_miss);
      delta[DTLB_MISS]   += XLEN'(events.dtlb_miss);
      delta[SB_FULL]     += XLEN'(events.sb_full);
      delta[IF_EMPTY]    += XLEN'(events.if_empty);
      delta[ERET]        += XLEN'(events.eret);
      next_cycle();
    end
    idle_inputs();
    // One cycle counted per edge since the base read
    delta[CYCLE] = 12;
    read_all_counters(now);
    for (int a = 0; a < NrPerfCounters; a++) begin
      check_count(now[a], base[a] + delta[a], $sformatf("counter %0d", a));
    end
    next_cycle();
  endtask

  task automatic counter_write_and_freeze();
    logic [NrPerfCounters-1:0][XLEN-1:0] base;
    logic [NrPerfCounters-1:0][XLEN-1:0] now;
    logic [XLEN-1:0]                     wval;
    wval = random_word();
    idle_inputs();
    // A retire in the write cycle must lose against the write
    commit_ack[0] = 1'b1;
    perf_addr     = INSTRET;
    perf_we       = 1'b1;
    perf_wdata    = wval;
    next_cycle();
    idle_inputs();
    read_all_counters(now);
    check_count(now[INSTRET], wval, "INSTRET after write");
    perf_addr = perf_addr_t'(5'd20);
    #0.1;
    check_count(perf_rdata, '0, "unmapped address");
    debug_mode = 1'b1;
    read_all_counters(base);
    for (int k = 0; k < 5; k++) begin
      commit_instr[0].pc = random_word();
      commit_ack         = '1;
      events             = '1;
      next_cycle();
    end
    idle_inputs();
    read_all_counters(now);
    for (int a = 0; a < NrPerfCounters; a++) begin
      check_count(now[a], base[a], $sformatf("frozen counter %0d", a));
    end
    debug_mode    = 1'b0;
    commit_ack[0] = 1'b1;
    next_cycle();
    idle_inputs();
    read_all_counters(now);
    check_count(now[CYCLE], base[CYCLE] + 1, "CYCLE after debug");
    check_count(now[INSTRET], base[INSTRET] + 1, "INSTRET after debug");
    next_cycle();
  endtask

  // ----------------------------
  // Main sequence and watchdog
  // ----------------------------
  initial begin
    seed         = 32'h4667_7a1d;
    errors       = 0;
    commit_instr = '0;
    commit_ack   = '0;
    priv_lvl     = PRIV_LVL_M;
    debug_mode   = 1'b0;
    events       = '0;
    perf_addr    = '0;
    perf_we      = 1'b0;
    perf_wdata   = '0;
    reset_state();
    trace_classification();
    single_port_stream();
    dual_port_arbitration();
    counter_accumulation();
    counter_write_and_freeze();
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(RunLimitNs);
    $display("Run timed out at %0t before the tests finished", $time);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/trace_pkg.sv
logic/commit_trace.sv
logic/pc_queue.sv
logic/pc_rr_arbiter.sv
logic/perf_counters.sv
logic/commit_monitor.sv
tb/tb_clock_gen.sv
tb/tb_commit_monitor.sv

/* Bender.yml */
package:
  name: commit_monitor

sources:
  - files:
      - logic/trace_pkg.sv
      - logic/commit_trace.sv
      - logic/pc_queue.sv
      - logic/pc_rr_arbiter.sv
      - logic/perf_counters.sv
      - logic/commit_monitor.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_commit_monitor.sv
